/* dcache_pkg.sv */
// shared widths and data types for the L1 data cache
// one line holds two 64-bit words, addressed by byte offset bit 3

package dcache_pkg;

    // ------------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------------

    // physical address seen by the core port and the miss port
    localparam int unsigned ADDR_WIDTH = 32;

    // core data word
    localparam int unsigned WORD_WIDTH = 64;

    // one cache line, also the refill beat from memory
    localparam int unsigned LINE_WIDTH = 128;

    // byte offset bits inside a line
    localparam int unsigned OFFSET_WIDTH = 4;

    // words per line, bit 3 of the address picks one
    localparam int unsigned WORDS_PER_LINE = 2;

    // ------------------------------------------------------------------------
    // data types
    // ------------------------------------------------------------------------

    // single data word
    typedef logic [WORD_WIDTH-1:0] dcache_word_t;

    // one enable per byte of a word
    typedef logic [WORD_WIDTH/8-1:0] dcache_be_t;

    // a line seen either as flat bits or as a word array
    // flat view for refill and memory, word view for select and merge
    typedef union packed {
        logic [LINE_WIDTH-1:0]             flat;
        dcache_word_t [WORDS_PER_LINE-1:0] words;
    } dcache_line_u;

endpackage

/* dcache_array_if.sv */
`timescale 1ns/10ps
// controller to tag/data array link of the L1 data cache
// read in one cycle, word writes and victim refills at the clock edge

interface dcache_array_if import dcache_pkg::*; #(
    parameter int unsigned NUM_WAYS = 2,
    parameter int unsigned NUM_SETS = 16
) ();

    localparam int unsigned INDEX_WIDTH = $clog2(NUM_SETS);
    localparam int unsigned TAG_WIDTH   = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;

    // request side, driven by the controller
    logic                    rd_en;
    logic                    wr_en;
    logic                    refill_en;
    logic [INDEX_WIDTH-1:0]  index;
    logic [TAG_WIDTH-1:0]    tag;
    logic [NUM_WAYS-1:0]     way_sel;
    dcache_line_u            wdata;
    logic [LINE_WIDTH/8-1:0] wbe;

    // lookup result, valid the cycle after rd_en
    logic                    hit;
    logic [NUM_WAYS-1:0]     hit_way;
    dcache_line_u            rline;

    modport ctrl (
        output rd_en, wr_en, refill_en, index, tag, way_sel, wdata, wbe,
        input  hit, hit_way, rline
    );

    modport array (
        input  rd_en, wr_en, refill_en, index, tag, way_sel, wdata, wbe,
        output hit, hit_way, rline
    );

endinterface

/* dcache_array.sv */
`timescale 1ns/10ps
// tag, valid and data storage of the set-associative data cache
// registered lookup with way compare, byte-masked word writes and
// round-robin victim refill per set

module dcache_array import dcache_pkg::*; #(
    parameter int unsigned NUM_WAYS = 2,
    parameter int unsigned NUM_SETS = 16
) (
    input logic           clk_i,
    input logic           rst_ni,
    dcache_array_if.array arr_port
);

    localparam int unsigned INDEX_WIDTH = $clog2(NUM_SETS);
    localparam int unsigned TAG_WIDTH   = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;
    localparam int unsigned VICT_WIDTH  = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1;
    localparam int unsigned LINE_BYTES  = LINE_WIDTH / 8;

    // storage, one entry per way and set
    logic [TAG_WIDTH-1:0]   tag_q  [NUM_WAYS][NUM_SETS];
    logic [LINE_WIDTH-1:0]  data_q [NUM_WAYS][NUM_SETS];
    logic [NUM_SETS-1:0]    valid_q [NUM_WAYS];
    logic [VICT_WIDTH-1:0]  victim_q [NUM_SETS];

    // lookup address held for the compare cycle
    logic [INDEX_WIDTH-1:0] rd_index_q;
    logic [TAG_WIDTH-1:0]   rd_tag_q;

    // one-hot way picked by the victim pointer of the addressed set
    logic [NUM_WAYS-1:0]    refill_way;

    // ------------------------------------------------------------------------
    // lookup
    // ------------------------------------------------------------------------

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_index_q <= '0;
        end else if (arr_port.rd_en) begin
            rd_index_q <= arr_port.index;
        end
    end

    always_ff @(posedge clk_i) begin
        if (arr_port.rd_en) begin
            rd_tag_q <= arr_port.tag;
        end
    end

    // compare every way against the stored tag, mux out the hitting line
    always_comb begin
        arr_port.hit_way = '0;
        arr_port.rline   = '0;
        for (int unsigned w = 0; w < NUM_WAYS; w++) begin
            if (valid_q[w][rd_index_q] && (tag_q[w][rd_index_q] == rd_tag_q)) begin
                arr_port.hit_way[w] = 1'b1;
                arr_port.rline.flat = data_q[w][rd_index_q];
            end
        end
    end

    assign arr_port.hit = |arr_port.hit_way;

    // ------------------------------------------------------------------------
    // writes
    // ------------------------------------------------------------------------

    always_comb begin
        refill_way = '0;
        for (int unsigned w = 0; w < NUM_WAYS; w++) begin
            if (victim_q[arr_port.index] == VICT_WIDTH'(w)) begin
                refill_way[w] = 1'b1;
            end
        end
    end

    // valid bits and victim pointers only move on a refill
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int unsigned w = 0; w < NUM_WAYS; w++) begin
                valid_q[w] <= '0;
            end
            for (int unsigned s = 0; s < NUM_SETS; s++) begin
                victim_q[s] <= '0;
            end
        end else if (arr_port.refill_en) begin
            for (int unsigned w = 0; w < NUM_WAYS; w++) begin
                if (refill_way[w]) begin
                    valid_q[w][arr_port.index] <= 1'b1;
                end
            end
            // round robin, wraps after the last way
            if (victim_q[arr_port.index] == VICT_WIDTH'(NUM_WAYS - 1)) begin
                victim_q[arr_port.index] <= '0;
            end else begin
                victim_q[arr_port.index] <= victim_q[arr_port.index] + 1'b1;
            end
        end
    end

    // refill replaces tag and whole line, a store only touches enabled bytes
    always_ff @(posedge clk_i) begin
        for (int unsigned w = 0; w < NUM_WAYS; w++) begin
            if (arr_port.refill_en && refill_way[w]) begin
                tag_q[w][arr_port.index]  <= arr_port.tag;
                data_q[w][arr_port.index] <= arr_port.wdata.flat;
            end else if (arr_port.wr_en && arr_port.way_sel[w]) begin
                for (int unsigned b = 0; b < LINE_BYTES; b++) begin
                    if (arr_port.wbe[b]) begin
                        data_q[w][arr_port.index][b*8 +: 8] <= arr_port.wdata.flat[b*8 +: 8];
                    end
                end
            end
        end
    end

    // a line is never resident in two ways, the controller only refills on a miss
    hit_way_onehot: assert property (
        @(posedge clk_i) disable iff (!rst_ni) $onehot0(arr_port.hit_way)
    ) else $error("dcache_array: more than one way hit");

endmodule

/* dcache_ctrl.sv */
`timescale 1ns/10ps
// request FSM of the L1 data cache
// serves load hits back to back, merges store hits, writes every store
// through the miss port and refills the victim way on a load miss

module dcache_ctrl import dcache_pkg::*; #(
    parameter int unsigned NUM_WAYS = 2,
    parameter int unsigned NUM_SETS = 16
) (
    input  logic              clk_i,
    input  logic              rst_ni,
    // core port
    input  logic              req_i,
    input  logic              we_i,
    input  logic              bypass_i,
    input  logic [ADDR_WIDTH-1:0] addr_i,
    input  dcache_word_t      wdata_i,
    input  dcache_be_t        be_i,
    output logic              gnt_o,
    output logic              rvalid_o,
    output logic              hit_o,
    output logic              busy_o,
    output dcache_word_t      rdata_o,
    // tag/data array
    dcache_array_if.ctrl      arr_port,
    // miss port
    output logic              miss_valid_o,
    output logic              miss_we_o,
    output logic              miss_bypass_o,
    output logic [ADDR_WIDTH-1:0] miss_addr_o,
    output dcache_word_t      miss_wdata_o,
    output dcache_be_t        miss_be_o,
    input  logic              miss_gnt_i,
    input  logic              miss_rvalid_i,
    input  dcache_line_u      miss_rdata_i
);

    localparam int unsigned INDEX_WIDTH = $clog2(NUM_SETS);
    localparam int unsigned TAG_WIDTH   = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;
    localparam int unsigned WSEL_WIDTH  = $clog2(WORDS_PER_LINE);
    localparam int unsigned WORD_BYTES  = WORD_WIDTH / 8;

    enum logic [2:0] {
        IDLE,
        LOOKUP,
        STORE_WRITE,
        MISS_REQ,
        REFILL
    } state_d, state_q;

    // saved request
    logic [ADDR_WIDTH-1:0] addr_q;
    dcache_word_t          wdata_q;
    dcache_be_t            be_q;
    logic                  we_q;
    logic                  bypass_q;
    logic [NUM_WAYS-1:0]   hit_way_q;

    logic                  save_req;
    logic                  save_hit_way;
    logic [WSEL_WIDTH-1:0] word_idx;

    // word of the line addressed by the saved request
    assign word_idx = addr_q[OFFSET_WIDTH-1 -: WSEL_WIDTH];
    assign busy_o   = (state_q != IDLE);

    // miss request fields come straight from the saved request
    // cached loads fetch the whole aligned line
    assign miss_addr_o   = (we_q || bypass_q) ? addr_q :
                           {addr_q[ADDR_WIDTH-1:OFFSET_WIDTH], {OFFSET_WIDTH{1'b0}}};
    assign miss_we_o     = we_q;
    assign miss_wdata_o  = wdata_q;
    assign miss_be_o     = be_q;
    assign miss_bypass_o = bypass_q;

    // ------------------------------------------------------------------------
    // FSM
    // ------------------------------------------------------------------------
    always_comb begin
        state_d      = state_q;
        save_req     = 1'b0;
        save_hit_way = 1'b0;
        gnt_o        = 1'b0;
        rvalid_o     = 1'b0;
        hit_o        = 1'b0;
        rdata_o      = '0;
        miss_valid_o = 1'b0;
        // array defaults follow the saved request
        arr_port.rd_en       = 1'b0;
        arr_port.wr_en       = 1'b0;
        arr_port.refill_en   = 1'b0;
        arr_port.index       = addr_q[OFFSET_WIDTH +: INDEX_WIDTH];
        arr_port.tag         = addr_q[ADDR_WIDTH-1 -: TAG_WIDTH];
        arr_port.way_sel     = hit_way_q;
        arr_port.wdata.words = {WORDS_PER_LINE{wdata_q}};
        arr_port.wbe         = '0;

        case (state_q)
            IDLE: begin
                if (req_i) begin
                    save_req = 1'b1;
                    // loads are granted on accept, stores only when done
                    gnt_o    = !we_i;
                    if (bypass_i) begin
                        state_d = MISS_REQ;
                    end else begin
                        arr_port.rd_en = 1'b1;
                        arr_port.index = addr_i[OFFSET_WIDTH +: INDEX_WIDTH];
                        arr_port.tag   = addr_i[ADDR_WIDTH-1 -: TAG_WIDTH];
                        state_d        = LOOKUP;
                    end
                end
            end

            LOOKUP: begin
                hit_o = arr_port.hit;
                if (we_q) begin
                    // store hit updates the array first, a miss does not allocate
                    save_hit_way = 1'b1;
                    state_d      = arr_port.hit ? STORE_WRITE : MISS_REQ;
                end else if (arr_port.hit) begin
                    rvalid_o = 1'b1;
                    rdata_o  = arr_port.rline.words[word_idx];
                    // next cached load starts its read while this one returns
                    if (req_i && !we_i && !bypass_i) begin
                        save_req       = 1'b1;
                        gnt_o          = 1'b1;
                        arr_port.rd_en = 1'b1;
                        arr_port.index = addr_i[OFFSET_WIDTH +: INDEX_WIDTH];
                        arr_port.tag   = addr_i[ADDR_WIDTH-1 -: TAG_WIDTH];
                    end else begin
                        state_d = IDLE;
                    end
                end else begin
                    state_d = MISS_REQ;
                end
            end

            STORE_WRITE: begin
                // merge the word into the hitting way, then write through
                arr_port.wr_en = 1'b1;
                arr_port.wbe[word_idx*WORD_BYTES +: WORD_BYTES] = be_q;
                state_d        = MISS_REQ;
            end

            MISS_REQ: begin
                miss_valid_o = 1'b1;
                if (miss_gnt_i) begin
                    if (we_q) begin
                        gnt_o   = 1'b1;
                        state_d = IDLE;
                    end else begin
                        state_d = REFILL;
                    end
                end
            end

            REFILL: begin
                if (miss_rvalid_i) begin
                    rvalid_o             = 1'b1;
                    rdata_o              = miss_rdata_i.words[word_idx];
                    // bypassed data never lands in the array
                    arr_port.refill_en   = !bypass_q;
                    arr_port.wdata       = miss_rdata_i;
                    state_d              = IDLE;
                end
            end

            default: begin
                state_d = IDLE;
            end
        endcase
    end

    // ------------------------------------------------------------------------
    // registers
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q  <= IDLE;
            we_q     <= 1'b0;
            bypass_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (save_req) begin
                we_q     <= we_i;
                bypass_q <= bypass_i;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (save_req) begin
            addr_q  <= addr_i;
            wdata_q <= wdata_i;
            be_q    <= be_i;
        end
        if (save_hit_way) begin
            hit_way_q <= arr_port.hit_way;
        end
    end

    // memory answers only the load it granted
    miss_rvalid_in_refill: assert property (
        @(posedge clk_i) disable iff (!rst_ni) miss_rvalid_i |-> (state_q == REFILL)
    ) else $error("dcache_ctrl: miss_rvalid_i outside of refill");

    // an ungranted miss request holds its fields
    miss_req_stable: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        (miss_valid_o && !miss_gnt_i) |=> (miss_valid_o && $stable(miss_addr_o) &&
            $stable(miss_we_o) && $stable(miss_wdata_o) && $stable(miss_be_o) &&
            $stable(miss_bypass_o))
    ) else $error("dcache_ctrl: miss request changed before grant");

endmodule

/* dcache_top.sv */
`timescale 1ns/10ps
// L1 data cache top level
// joins the request FSM and the tag/data array behind plain core and miss ports

module dcache_top import dcache_pkg::*; #(
    parameter int unsigned NUM_WAYS = 2,
    parameter int unsigned NUM_SETS = 16
) (
    input  logic              clk_i,
    input  logic              rst_ni,
    // core port
    input  logic              req_i,
    input  logic              we_i,
    input  logic [ADDR_WIDTH-1:0] addr_i,
    input  dcache_word_t      wdata_i,
    input  dcache_be_t        be_i,
    input  logic              bypass_i,
    output logic              gnt_o,
    output logic              rvalid_o,
    output dcache_word_t      rdata_o,
    output logic              hit_o,
    output logic              busy_o,
    // miss port
    output logic              miss_valid_o,
    output logic [ADDR_WIDTH-1:0] miss_addr_o,
    output logic              miss_we_o,
    output dcache_word_t      miss_wdata_o,
    output dcache_be_t        miss_be_o,
    output logic              miss_bypass_o,
    input  logic              miss_gnt_i,
    input  logic              miss_rvalid_i,
    input  dcache_line_u      miss_rdata_i
);

    // controller to array link
    dcache_array_if #(.NUM_WAYS(NUM_WAYS), .NUM_SETS(NUM_SETS)) arr_if ();

    dcache_ctrl #(
        .NUM_WAYS (NUM_WAYS),
        .NUM_SETS (NUM_SETS)
    ) u_ctrl (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .req_i         (req_i),
        .we_i          (we_i),
        .bypass_i      (bypass_i),
        .addr_i        (addr_i),
        .wdata_i       (wdata_i),
        .be_i          (be_i),
        .gnt_o         (gnt_o),
        .rvalid_o      (rvalid_o),
        .hit_o         (hit_o),
        .busy_o        (busy_o),
        .rdata_o       (rdata_o),
        .arr_port      (arr_if),
        .miss_valid_o  (miss_valid_o),
        .miss_we_o     (miss_we_o),
        .miss_bypass_o (miss_bypass_o),
        .miss_addr_o   (miss_addr_o),
        .miss_wdata_o  (miss_wdata_o),
        .miss_be_o     (miss_be_o),
        .miss_gnt_i    (miss_gnt_i),
        .miss_rvalid_i (miss_rvalid_i),
        .miss_rdata_i  (miss_rdata_i)
    );

    dcache_array #(
        .NUM_WAYS (NUM_WAYS),
        .NUM_SETS (NUM_SETS)
    ) u_array (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .arr_port (arr_if)
    );

endmodule

/* tb_dcache.sv */
`timescale 1ns/10ps
// testbench for the L1 data cache top level
// drives a table of core requests against a random-latency memory model
// and a reference tag table that predicts hit_o

module tb_dcache import dcache_pkg::*; ();

    localparam int unsigned SETS    = 16;
    localparam int unsigned WAYS    = 2;
    localparam int unsigned TIMEOUT = 200;

    // memory is kept per 64-bit word
    typedef logic [ADDR_WIDTH-4:0] word_key_t;

    typedef struct {
        bit                    we;
        logic [ADDR_WIDTH-1:0] addr;
        dcache_word_t          wdata;
        dcache_be_t            be;
        bit                    bypass;
    } stim_t;

    logic                  clk_i;
    logic                  rst_ni;
    logic                  req_i;
    logic                  we_i;
    logic                  bypass_i;
    logic [ADDR_WIDTH-1:0] addr_i;
    dcache_word_t          wdata_i;
    dcache_be_t            be_i;
    logic                  gnt_o;
    logic                  rvalid_o;
    logic                  hit_o;
    logic                  busy_o;
    dcache_word_t          rdata_o;
    logic                  miss_valid_o;
    logic                  miss_we_o;
    logic                  miss_bypass_o;
    logic [ADDR_WIDTH-1:0] miss_addr_o;
    dcache_word_t          miss_wdata_o;
    dcache_be_t            miss_be_o;
    logic                  miss_gnt_i;
    logic                  miss_rvalid_i;
    dcache_line_u          miss_rdata_i;

    // memory model contents and the last granted miss request
    dcache_word_t          model_mem [word_key_t];
    int unsigned           miss_count = 0;
    logic [ADDR_WIDTH-1:0] last_miss_addr;
    logic                  last_miss_we;
    logic                  last_miss_bypass;
    dcache_word_t          last_miss_wdata;
    dcache_be_t            last_miss_be;

    // reference state with index addr[7:4] and tag addr[31:8]
    dcache_word_t          ref_mem [word_key_t];
    logic [23:0]           ref_tag [SETS][WAYS];
    bit                    ref_valid [SETS][WAYS];
    logic                  ref_victim [SETS];

    stim_t                 stim_q [$];

    dcache_top dcache_top_inst (.*);

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    // ------------------------------------------------------------------------
    // reference model helpers
    // ------------------------------------------------------------------------

    function automatic word_key_t key_of(input logic [ADDR_WIDTH-1:0] a);
        return a[ADDR_WIDTH-1:3];
    endfunction

    // content of a word nobody has written yet
    function automatic dcache_word_t fill_word(input word_key_t key);
        return {3'b101, key, 3'b010, ~key};
    endfunction

    function automatic dcache_word_t merge_bytes(input dcache_word_t old_w,
                                                 input dcache_word_t new_w,
                                                 input dcache_be_t be);
        dcache_word_t res;
        res = old_w;
        for (int b = 0; b < 8; b++) begin
            if (be[b]) begin
                res[b*8 +: 8] = new_w[b*8 +: 8];
            end
        end
        return res;
    endfunction

    function automatic dcache_word_t model_read(input word_key_t key);
        return model_mem.exists(key) ? model_mem[key] : fill_word(key);
    endfunction

    function automatic dcache_word_t ref_read(input word_key_t key);
        return ref_mem.exists(key) ? ref_mem[key] : fill_word(key);
    endfunction

    function automatic bit ref_lookup(input logic [ADDR_WIDTH-1:0] a);
        logic [3:0] set;
        bit         found;
        set   = a[7:4];
        found = 1'b0;
        for (int w = 0; w < WAYS; w++) begin
            if (ref_valid[set][w] && (ref_tag[set][w] == a[31:8])) begin
                found = 1'b1;
            end
        end
        return found;
    endfunction

    // load miss allocates the round-robin victim
    task automatic ref_fill(input logic [ADDR_WIDTH-1:0] a);
        logic [3:0] set;
        set = a[7:4];
        ref_tag[set][ref_victim[set]]   = a[31:8];
        ref_valid[set][ref_victim[set]] = 1'b1;
        ref_victim[set]                 = ~ref_victim[set];
    endtask

    // ------------------------------------------------------------------------
    // memory model on the miss port
    // ------------------------------------------------------------------------

    initial begin : memory_model
        int unsigned           delay;
        logic [ADDR_WIDTH-1:0] base;
        miss_gnt_i    = 1'b0;
        miss_rvalid_i = 1'b0;
        miss_rdata_i  = '0;
        forever begin
            @(posedge clk_i);
            #1;
            if (miss_valid_o) begin
                // grant 1 to 4 cycles into the request
                delay = $urandom_range(1, 4);
                repeat (delay - 1) begin
                    @(posedge clk_i);
                    #1;
                end
                miss_gnt_i       = 1'b1;
                miss_count++;
                last_miss_addr   = miss_addr_o;
                last_miss_we     = miss_we_o;
                last_miss_bypass = miss_bypass_o;
                last_miss_wdata  = miss_wdata_o;
                last_miss_be     = miss_be_o;
                if (miss_we_o) begin
                    model_mem[key_of(miss_addr_o)] =
                        merge_bytes(model_read(key_of(miss_addr_o)), miss_wdata_o, miss_be_o);
                end
                @(posedge clk_i);
                #1;
                miss_gnt_i = 1'b0;
                if (!last_miss_we) begin
                    // whole aligned line comes 1 to 4 cycles after the grant
                    delay = $urandom_range(1, 4);
                    repeat (delay - 1) begin
                        @(posedge clk_i);
                        #1;
                    end
                    base = {last_miss_addr[ADDR_WIDTH-1:4], 4'h0};
                    miss_rdata_i.words[0] = model_read(key_of(base));
                    miss_rdata_i.words[1] = model_read(key_of(base + 8));
                    miss_rvalid_i         = 1'b1;
                    @(posedge clk_i);
                    #1;
                    miss_rvalid_i = 1'b0;
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------------

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input dcache_word_t got,
                              input dcache_word_t exp);
        if (got !== exp) begin
            fail_run($sformatf("MISMATCH t=%0t %s got %h exp %h", $time, name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("MISMATCH t=%0t %s got %b exp %b", $time, name, got, exp));
        end
    endtask

    task automatic check_addr(input string name, input logic [ADDR_WIDTH-1:0] got,
                              input logic [ADDR_WIDTH-1:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("MISMATCH t=%0t %s got %h exp %h", $time, name, got, exp));
        end
    endtask

    task automatic check_be(input string name, input dcache_be_t got, input dcache_be_t exp);
        if (got !== exp) begin
            fail_run($sformatf("MISMATCH t=%0t %s got %h exp %h", $time, name, got, exp));
        end
    endtask

    // waits on falling edges for gnt_o and collects any hit_o seen on the way
    task automatic wait_grant(output logic saw_hit);
        int unsigned cycles;
        cycles  = 0;
        saw_hit = 1'b0;
        @(negedge clk_i);
        while (!gnt_o) begin
            saw_hit = saw_hit | hit_o;
            cycles++;
            if (cycles == TIMEOUT) begin
                fail_run("timeout: the cache never raised gnt_o");
            end
            @(negedge clk_i);
        end
        saw_hit = saw_hit | hit_o;
    endtask

    // a load in flight keeps the cache busy until its data returns
    task automatic wait_rvalid();
        int unsigned cycles;
        cycles = 0;
        @(negedge clk_i);
        check_bit("busy_o", busy_o, 1'b1);
        while (!rvalid_o) begin
            cycles++;
            if (cycles == TIMEOUT) begin
                fail_run("timeout: a load never returned rvalid_o");
            end
            @(negedge clk_i);
            check_bit("busy_o", busy_o, 1'b1);
        end
    endtask

    // ------------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------------

    task automatic push_stim(input bit we, input logic [ADDR_WIDTH-1:0] addr,
                             input dcache_word_t wdata, input dcache_be_t be,
                             input bit bypass);
        stim_t e;
        e.we     = we;
        e.addr   = addr;
        e.wdata  = wdata;
        e.be     = be;
        e.bypass = bypass;
        stim_q.push_back(e);
    endtask

    // runs one request to completion and checks every visible result
    task automatic apply_entry(input stim_t e);
        bit                    exp_hit;
        dcache_word_t          exp_word;
        int unsigned           misses;
        logic                  saw_hit;
        logic [ADDR_WIDTH-1:0] exp_addr;
        exp_hit  = !e.bypass && ref_lookup(e.addr);
        exp_word = ref_read(key_of(e.addr));
        misses   = miss_count;
        @(posedge clk_i);
        #1;
        req_i    = 1'b1;
        we_i     = e.we;
        addr_i   = e.addr;
        wdata_i  = e.wdata;
        be_i     = e.be;
        bypass_i = e.bypass;
        wait_grant(saw_hit);
        @(posedge clk_i);
        #1;
        req_i = 1'b0;
        if (e.we) begin
            // write-through sends exactly one miss-port write
            ref_mem[key_of(e.addr)] = merge_bytes(exp_word, e.wdata, e.be);
            check_bit("hit_o", saw_hit, exp_hit);
            if (miss_count != misses + 1) begin
                fail_run("a store did not send exactly one write on the miss port");
            end
            check_bit("miss_we_o", last_miss_we, 1'b1);
            check_addr("miss_addr_o", last_miss_addr, e.addr);
            check_word("miss_wdata_o", last_miss_wdata, e.wdata);
            check_be("miss_be_o", last_miss_be, e.be);
            check_bit("miss_bypass_o", last_miss_bypass, e.bypass);
        end else begin
            wait_rvalid();
            check_word("rdata_o", rdata_o, exp_word);
            check_bit("hit_o", hit_o, exp_hit);
            if (exp_hit) begin
                if (miss_count != misses) begin
                    fail_run("a load hit sent a request on the miss port");
                end
            end else begin
                if (miss_count != misses + 1) begin
                    fail_run("a load miss did not send exactly one miss request");
                end
                // cached fetches are line aligned while bypassed ones keep the address
                exp_addr = e.bypass ? e.addr : {e.addr[ADDR_WIDTH-1:4], 4'h0};
                check_addr("miss_addr_o", last_miss_addr, exp_addr);
                check_bit("miss_we_o", last_miss_we, 1'b0);
                check_bit("miss_bypass_o", last_miss_bypass, e.bypass);
                if (!e.bypass) begin
                    ref_fill(e.addr);
                end
            end
        end
    endtask

    task automatic check_stream_result(input logic [ADDR_WIDTH-1:0] a);
        check_bit("rvalid_o", rvalid_o, 1'b1);
        check_word("rdata_o", rdata_o, ref_read(key_of(a)));
        check_bit("hit_o", hit_o, 1'b1);
    endtask

    // three back-to-back hits return one result per cycle
    task automatic run_hit_stream(input logic [ADDR_WIDTH-1:0] base);
        logic [ADDR_WIDTH-1:0] addrs [3];
        int unsigned           misses;
        addrs[0] = base;
        addrs[1] = base + 8;
        addrs[2] = base;
        misses   = miss_count;
        for (int k = 0; k < 3; k++) begin
            @(posedge clk_i);
            #1;
            req_i    = 1'b1;
            we_i     = 1'b0;
            bypass_i = 1'b0;
            addr_i   = addrs[k];
            @(negedge clk_i);
            check_bit("gnt_o", gnt_o, 1'b1);
            if (k > 0) begin
                check_stream_result(addrs[k-1]);
            end
        end
        @(posedge clk_i);
        #1;
        req_i = 1'b0;
        @(negedge clk_i);
        check_stream_result(addrs[2]);
        if (miss_count != misses) begin
            fail_run("the hit stream sent a request on the miss port");
        end
    endtask

    initial begin : stimulus
        int unsigned           line;
        logic [ADDR_WIDTH-1:0] addr;
        bit                    we;
        void'($urandom(32'h9101));
        rst_ni   = 1'b0;
        req_i    = 1'b0;
        we_i     = 1'b0;
        bypass_i = 1'b0;
        addr_i   = '0;
        wdata_i  = '0;
        be_i     = '0;
        for (int s = 0; s < SETS; s++) begin
            ref_victim[s] = 1'b0;
            for (int w = 0; w < WAYS; w++) begin
                ref_valid[s][w] = 1'b0;
            end
        end
        repeat (8) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        @(negedge clk_i);
        check_bit("gnt_o", gnt_o, 1'b0);
        check_bit("rvalid_o", rvalid_o, 1'b0);
        check_bit("hit_o", hit_o, 1'b0);
        check_bit("busy_o", busy_o, 1'b0);
        check_bit("miss_valid_o", miss_valid_o, 1'b0);

        // cold miss then hit, store hit, store miss, bypassed load
        push_stim(1'b0, 32'h0000_1040, '0, '0, 1'b0);
        push_stim(1'b0, 32'h0000_1048, '0, '0, 1'b0);
        push_stim(1'b1, 32'h0000_1048, 64'h1122_3344_5566_7788, 8'h0F, 1'b0);
        push_stim(1'b0, 32'h0000_1048, '0, '0, 1'b0);
        push_stim(1'b1, 32'h0000_2080, 64'hCAFE_F00D_0BAD_BEEF, 8'hF0, 1'b0);
        push_stim(1'b0, 32'h0000_2080, '0, '0, 1'b0);
        push_stim(1'b0, 32'h0000_1040, '0, '0, 1'b1);
        push_stim(1'b0, 32'h0000_1040, '0, '0, 1'b0);
        foreach (stim_q[i]) begin
            apply_entry(stim_q[i]);
        end

        run_hit_stream(32'h0000_1040);

        // 48 lines over 16 sets make three lines compete for two ways
        // bypass is drawn for loads only
        stim_q.delete();
        for (int n = 0; n < 200; n++) begin
            line = $urandom_range(0, 47);
            addr = 32'h0004_0000 + line * 16 + $urandom_range(0, 1) * 8;
            we   = ($urandom_range(0, 9) >= 6);
            push_stim(we, addr, {$urandom, $urandom}, dcache_be_t'($urandom_range(1, 255)),
                      !we && ($urandom_range(0, 7) == 0));
        end
        foreach (stim_q[i]) begin
            apply_entry(stim_q[i]);
        end

        $display("Regression passed");
        $finish;
    end

endmodule

/* dcache_top.f */
dcache_pkg.sv
dcache_array_if.sv
dcache_array.sv
dcache_ctrl.sv
dcache_top.sv
tb_dcache.sv

/* Makefile */
TOP = tb_dcache

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f dcache_top.f -o sim

run: build
	./obj_dir/sim | tee sim.log
	grep -q "Regression passed" sim.log

lint:
	verilator --lint-only --timing -Wall --top-module dcache_top -f dcache_top.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
